// ==== Bender.yml ====
package:
  name: spi_sys

sources:
  - common/spi_pkg.sv
  - hdl/spi_cfg_regs.sv
  - spi_master/spi_master.sv
  - hdl/spi_sys_top.sv
  - target: test
    files:
      - test/spi_slave_model.sv
      - test/spi_sys_chk.sv
      - test/tb_spi_sys.sv

// ==== common/spi_pkg.sv ====
`default_nettype none

package spi_pkg;

  // Command word layout of the register device.
  localparam int CMD_WIDTH  = 12;
  localparam int READ_WIDTH = 8;
  localparam int HDR_BITS   = 4;  // Write flag plus 3-bit address.

  localparam int BIT_CNT_W  = $clog2(CMD_WIDTH);

  // Configuration register width and reset values.
  localparam int CFG_DW = 8;
  localparam logic [CFG_DW-1:0] CLK_DIV_RST  = 8'd4;
  localparam logic [CFG_DW-1:0] READ_GAP_RST = 8'd8;

  // Master sequencing states.
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    W_SHIFT = 3'd1,
    W_DONE  = 3'd2,
    R_HDR   = 3'd3,
    R_GAP   = 3'd4,
    R_SHIFT = 3'd5,
    R_DONE  = 3'd6
  } spi_state_e;

  // Host view of the configuration block.
  typedef enum logic [1:0] {
    CFG_CLK_DIV  = 2'd0,
    CFG_READ_GAP = 2'd1,
    CFG_XFER_CNT = 2'd2
  } cfg_addr_e;

endpackage

`default_nettype wire

// ==== filelist.f ====
common/spi_pkg.sv
hdl/spi_cfg_regs.sv
spi_master/spi_master.sv
hdl/spi_sys_top.sv
test/spi_slave_model.sv
test/spi_sys_chk.sv
test/tb_spi_sys.sv

// ==== hdl/spi_cfg_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_cfg_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cfg_wr,
  input  spi_pkg::cfg_addr_e         cfg_addr,
  input  logic [spi_pkg::CFG_DW-1:0] cfg_wdata,
  output logic [spi_pkg::CFG_DW-1:0] cfg_rdata,
  input  logic                       xfer_done,
  output logic [spi_pkg::CFG_DW-1:0] clk_div,
  output logic [spi_pkg::CFG_DW-1:0] read_gap
);

  import spi_pkg::*;

  logic [CFG_DW-1:0] xfer_cnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      clk_div  <= CLK_DIV_RST;
      read_gap <= READ_GAP_RST;
    end
    else if (cfg_wr)
    begin
      case (cfg_addr)
        CFG_CLK_DIV:
        begin
          // A divider of zero would stall the master.
          clk_div <= (cfg_wdata == '0) ? 8'd1 : cfg_wdata;
        end
        CFG_READ_GAP: read_gap <= cfg_wdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      xfer_cnt <= '0;
    end
    else if (cfg_wr && cfg_addr == CFG_XFER_CNT)
    begin
      xfer_cnt <= '0;  // Any write clears.
    end
    else if (xfer_done && xfer_cnt != 8'hff)
    begin
      xfer_cnt <= xfer_cnt + 8'd1;
    end
  end

  always_comb
  begin
    case (cfg_addr)
      CFG_CLK_DIV:  cfg_rdata = clk_div;
      CFG_READ_GAP: cfg_rdata = read_gap;
      CFG_XFER_CNT: cfg_rdata = xfer_cnt;
      default:      cfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/spi_sys_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_sys_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [spi_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                           cmd_vld,
  output logic                           cmd_rdy,
  output logic [spi_pkg::READ_WIDTH-1:0] read_data,
  output logic                           read_vld,
  input  logic                           cfg_wr,
  input  spi_pkg::cfg_addr_e             cfg_addr,
  input  logic [spi_pkg::CFG_DW-1:0]     cfg_wdata,
  output logic [spi_pkg::CFG_DW-1:0]     cfg_rdata,
  output logic                           sclk,
  output logic                           cs,
  output logic                           mosi,
  input  logic                           miso
);

  import spi_pkg::*;

  logic [CFG_DW-1:0] clk_div;
  logic [CFG_DW-1:0] read_gap;
  logic              xfer_done;

  spi_cfg_regs u_cfg (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .xfer_done (xfer_done),
    .clk_div   (clk_div),
    .read_gap  (read_gap)
  );

  spi_master u_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_vld  (read_vld),
    .clk_div   (clk_div),
    .read_gap  (read_gap),
    .xfer_done (xfer_done),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso)
  );

endmodule

`default_nettype wire

// ==== spi_master/spi_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_master (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [spi_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                           cmd_vld,
  output logic                           cmd_rdy,
  output logic [spi_pkg::READ_WIDTH-1:0] read_data,
  output logic                           read_vld,
  input  logic [spi_pkg::CFG_DW-1:0]     clk_div,
  input  logic [spi_pkg::CFG_DW-1:0]     read_gap,
  output logic                           xfer_done,
  output logic                           sclk,
  output logic                           cs,
  output logic                           mosi,
  input  logic                           miso
);

  import spi_pkg::*;

  spi_state_e state;

  logic [CMD_WIDTH-1:0]  tx_sh;
  logic [READ_WIDTH-1:0] rx_sh;
  logic [CFG_DW-1:0]     div_q;
  logic [CFG_DW-1:0]     gap_q;
  logic [CFG_DW-1:0]     phase;
  logic [CFG_DW-1:0]     gap_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [BIT_CNT_W-1:0]  bit_last;

  logic accept;
  logic shifting;
  logic half_end;
  logic rise;
  logic fall;

  assign accept   = cmd_vld && cmd_rdy;
  assign shifting = (state == W_SHIFT) || (state == R_HDR) || (state == R_SHIFT);
  assign half_end = (phase == div_q - 8'd1);
  assign rise     = shifting && half_end && !sclk;
  assign fall     = shifting && half_end && sclk;

  // Index of the final bit in the current shift phase.
  always_comb
  begin
    case (state)
      W_SHIFT: bit_last = BIT_CNT_W'(CMD_WIDTH - 1);
      R_HDR:   bit_last = BIT_CNT_W'(HDR_BITS - 1);
      default: bit_last = BIT_CNT_W'(READ_WIDTH - 1);
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      cmd_rdy   <= 1'b1;
      cs        <= 1'b1;
      sclk      <= 1'b0;
      mosi      <= 1'b0;
      read_vld  <= 1'b0;
      xfer_done <= 1'b0;
      phase     <= '0;
      bit_cnt   <= '0;
      gap_cnt   <= '0;
    end
    else
    begin
      read_vld  <= 1'b0;
      xfer_done <= 1'b0;
      case (state)
        IDLE:
        begin
          if (accept)
          begin
            state   <= cmd_in[CMD_WIDTH-1] ? W_SHIFT : R_HDR;  // Write flag.
            cmd_rdy <= 1'b0;
            cs      <= 1'b0;
            mosi    <= cmd_in[CMD_WIDTH-1];
            phase   <= '0;
            bit_cnt <= '0;
          end
        end
        W_SHIFT, R_HDR, R_SHIFT:
        begin
          if (half_end)
          begin
            phase <= '0;
            sclk  <= ~sclk;
            if (sclk)
            begin
              // Falling edge closes one bit.
              if (state != R_SHIFT)
              begin
                mosi <= (bit_cnt == bit_last) ? 1'b0 : tx_sh[CMD_WIDTH-2];
              end
              if (bit_cnt == bit_last)
              begin
                bit_cnt <= '0;
                case (state)
                  W_SHIFT: state <= W_DONE;
                  R_HDR:
                  begin
                    state   <= R_GAP;
                    cs      <= 1'b1;
                    gap_cnt <= '0;
                  end
                  default: state <= R_DONE;
                endcase
              end
              else
              begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
          end
          else
          begin
            phase <= phase + 8'd1;
          end
        end
        R_GAP:
        begin
          if (gap_cnt + 8'd1 >= gap_q)
          begin
            state <= R_SHIFT;
            cs    <= 1'b0;
          end
          else
          begin
            gap_cnt <= gap_cnt + 8'd1;
          end
        end
        W_DONE, R_DONE:
        begin
          state     <= IDLE;
          cs        <= 1'b1;
          cmd_rdy   <= 1'b1;
          xfer_done <= 1'b1;
          read_vld  <= (state == R_DONE);
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Command and timing captured at acceptance, shift data follows sclk.
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      tx_sh <= cmd_in;
      div_q <= clk_div;
      gap_q <= read_gap;
    end
    else if (fall)
    begin
      tx_sh <= {tx_sh[CMD_WIDTH-2:0], 1'b0};
    end

    if (rise && state == R_SHIFT)
    begin
      rx_sh <= {rx_sh[READ_WIDTH-2:0], miso};  // Mode 0 sample point.
    end

    if (state == R_DONE)
    begin
      read_data <= rx_sh;
    end
  end

endmodule

`default_nettype wire

// ==== test/spi_slave_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_slave_model (
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso
);

  logic [7:0]  regs [0:7];
  logic [11:0] rx_word    = '0;
  logic [7:0]  tx_byte    = '0;
  logic [2:0]  rd_addr    = '0;
  logic        rd_pend    = 1'b0;
  logic        data_phase = 1'b0;
  logic        sclk_prev  = 1'b0;
  int          bit_cnt    = 0;

  initial
  begin
    for (int i = 0; i < 8; i++)
    begin
      regs[i] = '0;
    end
  end

  assign miso = data_phase ? tx_byte[7] : 1'b0;

  always @(negedge cs or posedge sclk or negedge sclk)
  begin
    if (sclk !== sclk_prev)
    begin
      if (sclk && !cs && !data_phase)
      begin
        rx_word = {rx_word[10:0], mosi};  // Mode 0, sample on the rising edge.
        bit_cnt++;
        if (bit_cnt == 4 && !rx_word[3])
        begin
          rd_pend = 1'b1;
          rd_addr = rx_word[2:0];
        end
        if (bit_cnt == 12)
        begin
          regs[rx_word[10:8]] = rx_word[7:0];
        end
      end
      else if (!sclk && !cs && data_phase)
      begin
        tx_byte = {tx_byte[6:0], 1'b0};  // Next bit out on the falling edge.
      end
    end
    else if (cs === 1'b0)
    begin
      // The frame after a read header returns the register.
      bit_cnt    = 0;
      data_phase = rd_pend;
      rd_pend    = 1'b0;
      tx_byte    = regs[rd_addr];
    end
    sclk_prev = sclk;
  end

endmodule

`default_nettype wire

// ==== test/spi_sys_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_sys_chk (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       cmd_vld,
  input logic                       cmd_rdy,
  input logic                       read_vld,
  input logic                       sclk,
  input logic                       cs,
  input logic [spi_pkg::CFG_DW-1:0] div_q
);

  int unsigned fail_cnt = 0;
  int unsigned busy_cycles;

  // Busy cycles since the last accepted command.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_cycles <= 0;
    end
    else if (cmd_vld && cmd_rdy)
    begin
      busy_cycles <= 0;
    end
    else if (!cmd_rdy)
    begin
      busy_cycles <= busy_cycles + 1;
    end
  end

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk)
    else
    begin
      $error("sclk is high while cs is high");
      fail_cnt++;
    end

  a_read_vld: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> cmd_rdy && !$past(cmd_rdy))
    else
    begin
      $error("read_vld without a rising cmd_rdy");
      fail_cnt++;
    end

  a_busy_min: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> busy_cycles >= 2 * div_q)
    else
    begin
      $error("cmd_rdy returned before one full sclk period");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== test/tb_spi_sys.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_spi_sys;

  import spi_pkg::*;

  localparam int TIMEOUT = 5000;

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic [READ_WIDTH-1:0] read_data;
  logic                  read_vld;
  logic                  cfg_wr;
  cfg_addr_e             cfg_addr;
  logic [CFG_DW-1:0]     cfg_wdata;
  logic [CFG_DW-1:0]     cfg_rdata;
  logic                  sclk;
  logic                  cs;
  logic                  mosi;
  logic                  miso;

  logic [31:0] lfsr = 32'hb68;
  logic [7:0]  mirror [0:7];
  int          cur_div;
  int          cur_gap;
  int          exp_xfers;
  int          err_cnt;
  int          timeout_cnt;

  spi_sys_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_vld  (read_vld),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso)
  );

  spi_slave_model u_slave (
    .sclk (sclk),
    .cs   (cs),
    .mosi (mosi),
    .miso (miso)
  );

  bind spi_master spi_sys_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .read_vld (read_vld),
    .sclk     (sclk),
    .cs       (cs),
    .div_q    (div_q)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_read(input string name, input logic [READ_WIDTH-1:0] exp,
                            input logic [READ_WIDTH-1:0] act);
    if (act !== exp)
    begin
      $display("ERR %s: expected %h, got %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_cfg(input string name, input logic [CFG_DW-1:0] exp,
                           input logic [CFG_DW-1:0] act);
    if (act !== exp)
    begin
      $display("ERR %s: expected %h, got %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_pin(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERR %s: expected %h, got %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("ERR %s: expected %h, got %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic wait_ready();
    int n = 0;
    @(negedge clk);
    while (!cmd_rdy && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy)
    begin
      $display("Timeout: cmd_rdy did not return high");
      timeout_cnt++;
    end
  endtask

  task automatic set_cfg(input cfg_addr_e addr, input logic [CFG_DW-1:0] data);
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_wr <= 1'b0;
    case (addr)
      CFG_CLK_DIV:  cur_div = data;
      CFG_READ_GAP: cur_gap = data;
      default:      exp_xfers = 0;  // Any write clears the counter.
    endcase
  endtask

  task automatic expect_cfg(input cfg_addr_e addr, input int exp);
    @(posedge clk);
    cfg_addr <= addr;
    @(negedge clk);
    check_cfg($sformatf("cfg_rdata (%s)", addr.name()), CFG_DW'(exp), cfg_rdata);
  endtask

  // Issue one command and follow the pins until cmd_rdy returns.
  task automatic run_cmd(input logic [CMD_WIDTH-1:0] cmd,
                         output logic [READ_WIDTH-1:0] rdata);
    int   lat       = 0;
    int   gap       = 0;
    int   run       = 0;
    logic last_sclk = 1'b0;
    wait_ready();
    @(posedge clk);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    @(negedge clk);
    while (!cmd_rdy && lat < TIMEOUT)
    begin
      lat++;
      if (sclk != last_sclk)
      begin
        check_count("sclk interval", cur_div, run);
        run = 0;
      end
      last_sclk = sclk;
      if (cs)
      begin
        gap++;
        run = 0;
      end
      else
      begin
        run++;
      end
      @(negedge clk);
    end
    if (!cmd_rdy)
    begin
      $display("Timeout: command %h did not complete", cmd);
      timeout_cnt++;
    end
    exp_xfers = (exp_xfers < 255) ? exp_xfers + 1 : 255;
    check_pin("read_vld", !cmd[CMD_WIDTH-1], read_vld);
    rdata = read_data;
    if (cmd[CMD_WIDTH-1])
    begin
      check_count("cmd_rdy latency", 1 + 2 * CMD_WIDTH * cur_div, lat);
    end
    else
    begin
      check_count("cs gap", cur_gap, gap);
    end
  endtask

  task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
    logic [READ_WIDTH-1:0] unused;
    run_cmd({1'b1, addr, data}, unused);
    mirror[addr] = data;
  endtask

  task automatic read_reg(input logic [2:0] addr);
    logic [READ_WIDTH-1:0] rdata;
    run_cmd({1'b0, addr, 8'h00}, rdata);
    check_read($sformatf("read_data (reg %0d)", addr), mirror[addr], rdata);
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_pin("cmd_rdy", 1'b1, cmd_rdy);
    check_pin("cs", 1'b1, cs);
    check_pin("sclk", 1'b0, sclk);
    check_pin("read_vld", 1'b0, read_vld);
    expect_cfg(CFG_CLK_DIV, 4);
    expect_cfg(CFG_READ_GAP, 8);
    expect_cfg(CFG_XFER_CNT, 0);
  endtask

  task automatic test_write_read();
    for (int a = 0; a < 8; a++)
    begin
      write_reg(3'(a), 8'(random_bits(8)));
    end
    for (int a = 0; a < 8; a++)
    begin
      read_reg(3'(a));
    end
  endtask

  task automatic test_divider();
    int divs [3] = '{1, 3, 7};
    foreach (divs[i])
    begin
      set_cfg(CFG_CLK_DIV, CFG_DW'(divs[i]));
      expect_cfg(CFG_CLK_DIV, divs[i]);
      write_reg(3'(random_bits(3)), 8'(random_bits(8)));
      read_reg(3'(random_bits(3)));
    end
    set_cfg(CFG_CLK_DIV, 8'd4);
  endtask

  task automatic test_read_gap();
    int gaps [2] = '{2, 20};
    foreach (gaps[i])
    begin
      set_cfg(CFG_READ_GAP, CFG_DW'(gaps[i]));
      read_reg(3'(random_bits(3)));
    end
    set_cfg(CFG_READ_GAP, 8'd8);
  endtask

  task automatic test_busy();
    logic [2:0] a;
    logic [2:0] b;
    logic [7:0] d;
    a = 3'(random_bits(3));
    b = a + 3'd1;
    d = 8'(random_bits(8));
    wait_ready();
    @(posedge clk);
    cmd_in  <= {1'b1, a, d};
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_in <= {1'b1, b, ~mirror[b]};  // Offered while busy.
    repeat (8) @(posedge clk);
    cmd_vld <= 1'b0;
    wait_ready();
    mirror[a] = d;
    exp_xfers = (exp_xfers < 255) ? exp_xfers + 1 : 255;
    read_reg(a);
    read_reg(b);
    expect_cfg(CFG_XFER_CNT, exp_xfers);
  endtask

  task automatic test_xfer_count();
    expect_cfg(CFG_XFER_CNT, exp_xfers);
    set_cfg(CFG_XFER_CNT, 8'h00);
    expect_cfg(CFG_XFER_CNT, 0);
    for (int i = 0; i < 3; i++)
    begin
      write_reg(3'(random_bits(3)), 8'(random_bits(8)));
      read_reg(3'(random_bits(3)));
    end
    expect_cfg(CFG_XFER_CNT, exp_xfers);
  endtask

  initial
  begin
    rst_n       = 1'b0;
    cmd_in      = '0;
    cmd_vld     = 1'b0;
    cfg_wr      = 1'b0;
    cfg_addr    = CFG_CLK_DIV;
    cfg_wdata   = '0;
    cur_div     = 4;
    cur_gap     = 8;
    exp_xfers   = 0;
    err_cnt     = 0;
    timeout_cnt = 0;
    for (int i = 0; i < 8; i++)
    begin
      mirror[i] = '0;
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    test_reset();
    test_write_read();
    test_divider();
    test_read_gap();
    test_busy();
    test_xfer_count();

    $display("Check errors: %0d, timeouts: %0d, assertion failures: %0d",
             err_cnt, timeout_cnt, DUT.u_master.u_chk.fail_cnt);
    if (err_cnt == 0 && timeout_cnt == 0 && DUT.u_master.u_chk.fail_cnt == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
